// File: Bender.yml
package:
  name: rv32i_pipeline

dependencies: {}

sources:
  # packages first, then the datapath blocks and the top level
  - logic/rv_isa_pkg.sv
  - logic/pipe_pkg.sv
  - logic/fetch_unit.sv
  - logic/decode_control.sv
  - logic/register_file.sv
  - logic/alu.sv
  - logic/hazard_unit.sv
  - logic/cpu_pipeline.sv

  # testbench
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/cpu_tb.sv

// File: list.f
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_unit.sv
logic/decode_control.sv
logic/register_file.sv
logic/alu.sv
logic/hazard_unit.sv
logic/cpu_pipeline.sv
verification/tb_clock_gen.sv
verification/cpu_tb.sv

// File: logic/alu.sv
module alu (
	input  pipe_pkg::alu_op_e op,
	input  rv_isa_pkg::word_t a,
	input  rv_isa_pkg::word_t b,
	output rv_isa_pkg::word_t result,
	output logic              equal
);
	import rv_isa_pkg::*;
	import pipe_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			// signed compare
			ALU_SLT: result = word_t'($signed(a) < $signed(b));
			default: result = '0;
		endcase
	end

	// beq decision, independent of op
	assign equal = (a == b);

endmodule

// File: logic/cpu_pipeline.sv
module cpu_pipeline #(
	parameter rv_isa_pkg::word_t RESET_PC = '0
) (
	input  logic              clock,
	input  logic              reset,
	output rv_isa_pkg::word_t fetch_pc,
	input  rv_isa_pkg::word_t instruction,
	output rv_isa_pkg::word_t data_addr,
	output rv_isa_pkg::word_t write_data,
	output logic              mem_read,
	output logic              mem_write,
	input  rv_isa_pkg::word_t read_data
);
	import rv_isa_pkg::*;
	import pipe_pkg::*;

	logic stall, flush, redirect, equal;
	word_t target, alu_a, alu_b, alu_result, operand_a, operand_b, wb_data;
	fwd_sel_e fwd_a, fwd_b;

	// decode stage
	word_t id_instruction, id_pc, id_imm, id_data_a, id_data_b;
	reg_addr_t id_rs1, id_rs2, id_rd;
	alu_op_e id_alu_op;
	logic id_use_imm, id_reg_write, id_mem_read, id_mem_write;
	logic id_mem_to_reg, id_is_branch, id_is_jump;

	// execute stage
	word_t ex_pc, ex_imm, ex_data_a, ex_data_b;
	reg_addr_t ex_rs1, ex_rs2, ex_rd;
	alu_op_e ex_alu_op;
	logic ex_use_imm, ex_reg_write, ex_mem_read, ex_mem_write;
	logic ex_mem_to_reg, ex_is_branch, ex_is_jump;

	// memory and writeback stages
	word_t mem_alu_result, mem_store_data, wb_alu_result, wb_load_data;
	reg_addr_t mem_rd, wb_rd;
	logic mem_reg_write, mem_mem_to_reg, wb_reg_write, wb_mem_to_reg;

	////////////////////////////////////////////////////////////////////////////
	// fetch
	////////////////////////////////////////////////////////////////////////////
	fetch_unit #(.RESET_PC(RESET_PC)) fetch_i (
		.clock(clock), .reset(reset), .stall(stall), .redirect(redirect),
		.target(target), .pc(fetch_pc)
	);

	// a zero word decodes as a no-op
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			id_instruction <= '0;
			id_pc          <= '0;
		end else if (flush) begin
			id_instruction <= '0;
		end else if (!stall) begin
			id_instruction <= instruction;
			id_pc          <= fetch_pc;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////////////////////
	decode_control decode_i (
		.instruction(id_instruction), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd),
		.imm(id_imm), .alu_op(id_alu_op), .use_imm(id_use_imm),
		.reg_write(id_reg_write), .mem_read(id_mem_read), .mem_write(id_mem_write),
		.mem_to_reg(id_mem_to_reg), .is_branch(id_is_branch), .is_jump(id_is_jump)
	);

	register_file regs_i (
		.clock(clock), .reset(reset), .read_a(id_rs1), .read_b(id_rs2),
		.data_a(id_data_a), .data_b(id_data_b), .write_addr(wb_rd),
		.write_enable(wb_reg_write), .write_data(wb_data)
	);

	hazard_unit hazard_i (
		.id_rs1(id_rs1), .id_rs2(id_rs2), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2),
		.ex_rd(ex_rd), .mem_rd(mem_rd), .wb_rd(wb_rd), .ex_mem_read(ex_mem_read),
		.mem_reg_write(mem_reg_write), .wb_reg_write(wb_reg_write),
		.redirect(redirect), .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall), .flush(flush)
	);

	// bubble on load-use and on a taken branch or jump
	always_ff @(posedge clock or negedge reset) begin
		if (!reset || flush || stall) begin
			ex_alu_op     <= ALU_ADD;
			ex_use_imm    <= 1'b0;
			ex_reg_write  <= 1'b0;
			ex_mem_read   <= 1'b0;
			ex_mem_write  <= 1'b0;
			ex_mem_to_reg <= 1'b0;
			ex_is_branch  <= 1'b0;
			ex_is_jump    <= 1'b0;
		end else begin
			ex_alu_op     <= id_alu_op;
			ex_use_imm    <= id_use_imm;
			ex_reg_write  <= id_reg_write;
			ex_mem_read   <= id_mem_read;
			ex_mem_write  <= id_mem_write;
			ex_mem_to_reg <= id_mem_to_reg;
			ex_is_branch  <= id_is_branch;
			ex_is_jump    <= id_is_jump;
		end
	end

	always_ff @(posedge clock) begin
		ex_pc     <= id_pc;
		ex_imm    <= id_imm;
		ex_data_a <= id_data_a;
		ex_data_b <= id_data_b;
		ex_rs1    <= id_rs1;
		ex_rs2    <= id_rs2;
		ex_rd     <= id_rd;
	end

	////////////////////////////////////////////////////////////////////////////
	// execute
	////////////////////////////////////////////////////////////////////////////
	function automatic word_t forward(fwd_sel_e sel, word_t reg_value, word_t mem_value,
			word_t wb_value);
		case (sel)
			FWD_MEM: return mem_value;
			FWD_WB:  return wb_value;
			default: return reg_value;
		endcase
	endfunction

	assign operand_a = forward(fwd_a, ex_data_a, mem_alu_result, wb_data);
	assign operand_b = forward(fwd_b, ex_data_b, mem_alu_result, wb_data);

	// jal links pc plus four through the ALU
	assign alu_a = ex_is_jump ? ex_pc : operand_a;
	assign alu_b = ex_is_jump ? word_t'(4) : (ex_use_imm ? ex_imm : operand_b);

	alu alu_i (.op(ex_alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .equal(equal));

	assign target   = ex_pc + ex_imm;
	assign redirect = ex_is_jump || (ex_is_branch && equal);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			mem_reg_write  <= 1'b0;
			mem_read       <= 1'b0;
			mem_write      <= 1'b0;
			mem_mem_to_reg <= 1'b0;
		end else begin
			mem_reg_write  <= ex_reg_write;
			mem_read       <= ex_mem_read;
			mem_write      <= ex_mem_write;
			mem_mem_to_reg <= ex_mem_to_reg;
		end
	end

	always_ff @(posedge clock) begin
		mem_rd         <= ex_rd;
		mem_alu_result <= alu_result;
		mem_store_data <= operand_b;
	end

	////////////////////////////////////////////////////////////////////////////
	// memory and writeback
	////////////////////////////////////////////////////////////////////////////
	assign data_addr  = mem_alu_result;
	assign write_data = mem_store_data;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb_reg_write  <= 1'b0;
			wb_mem_to_reg <= 1'b0;
		end else begin
			wb_reg_write  <= mem_reg_write;
			wb_mem_to_reg <= mem_mem_to_reg;
		end
	end

	always_ff @(posedge clock) begin
		wb_rd         <= mem_rd;
		wb_alu_result <= mem_alu_result;
		wb_load_data  <= read_data;
	end

	assign wb_data = wb_mem_to_reg ? wb_load_data : wb_alu_result;

	// decode gives each instruction at most one memory strobe
	a_one_strobe: assert property (@(posedge clock) disable iff (!reset)
		!(mem_read && mem_write));

endmodule

// File: logic/decode_control.sv
module decode_control (
	input  rv_isa_pkg::word_t     instruction,
	output rv_isa_pkg::reg_addr_t rs1,
	output rv_isa_pkg::reg_addr_t rs2,
	output rv_isa_pkg::reg_addr_t rd,
	output rv_isa_pkg::word_t     imm,
	output pipe_pkg::alu_op_e     alu_op,
	output logic                  use_imm,
	output logic                  reg_write,
	output logic                  mem_read,
	output logic                  mem_write,
	output logic                  mem_to_reg,
	output logic                  is_branch,
	output logic                  is_jump
);
	import rv_isa_pkg::*;
	import pipe_pkg::*;

	opcode_e             opcode;
	logic [FUNCT3_W-1:0] funct3;
	logic [FUNCT7_W-1:0] funct7;

	assign opcode = opcode_e'(instruction[6:0]);
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];
	assign rs1    = instruction[19:15];
	assign rs2    = instruction[24:20];
	assign rd     = instruction[11:7];

	// immediate format follows the opcode
	always_comb begin
		case (opcode)
			OP_IMM, LOAD: imm = {{20{instruction[31]}}, instruction[31:20]};
			STORE:        imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
			BRANCH: imm = {{19{instruction[31]}}, instruction[31], instruction[7],
				instruction[30:25], instruction[11:8], 1'b0};
			JAL: imm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
				instruction[20], instruction[30:21], 1'b0};
			default: imm = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// control set
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		// no-op unless a kept opcode matches
		alu_op     = ALU_ADD;
		use_imm    = 1'b0;
		reg_write  = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_to_reg = 1'b0;
		is_branch  = 1'b0;
		is_jump    = 1'b0;
		case (opcode)
			OP: begin
				reg_write = 1'b1;
				case (funct3)
					FUNCT3_ADD_SUB: alu_op = (funct7 == FUNCT7_SUB) ? ALU_SUB : ALU_ADD;
					FUNCT3_SLT:     alu_op = ALU_SLT;
					FUNCT3_XOR:     alu_op = ALU_XOR;
					FUNCT3_OR:      alu_op = ALU_OR;
					FUNCT3_AND:     alu_op = ALU_AND;
					default:        reg_write = 1'b0;
				endcase
			end
			OP_IMM: begin
				// addi only
				use_imm   = 1'b1;
				reg_write = (funct3 == FUNCT3_ADD_SUB);
			end
			LOAD: begin
				use_imm    = 1'b1;
				reg_write  = 1'b1;
				mem_read   = 1'b1;
				mem_to_reg = 1'b1;
			end
			STORE: begin
				use_imm   = 1'b1;
				mem_write = 1'b1;
			end
			BRANCH: begin
				alu_op    = ALU_SUB;
				is_branch = 1'b1;
			end
			JAL: begin
				reg_write = 1'b1;
				is_jump   = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: logic/fetch_unit.sv
module fetch_unit #(
	parameter rv_isa_pkg::word_t RESET_PC = '0
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              stall,
	input  logic              redirect,
	input  rv_isa_pkg::word_t target,
	output rv_isa_pkg::word_t pc
);
	import rv_isa_pkg::*;

	word_t next_pc;

	// redirect from execute beats a load-use hold
	always_comb begin
		if (redirect) begin
			next_pc = target;
		end else if (stall) begin
			next_pc = pc;
		end else begin
			next_pc = pc + word_t'(4);
		end
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= RESET_PC;
		end else begin
			pc <= next_pc;
		end
	end

	// targets come from pc plus an even immediate, so alignment must hold
	a_pc_aligned: assert property (@(posedge clock) disable iff (!reset)
		pc[1:0] == 2'b00);

endmodule

// File: logic/hazard_unit.sv
module hazard_unit (
	input  rv_isa_pkg::reg_addr_t id_rs1,
	input  rv_isa_pkg::reg_addr_t id_rs2,
	input  rv_isa_pkg::reg_addr_t ex_rs1,
	input  rv_isa_pkg::reg_addr_t ex_rs2,
	input  rv_isa_pkg::reg_addr_t ex_rd,
	input  rv_isa_pkg::reg_addr_t mem_rd,
	input  rv_isa_pkg::reg_addr_t wb_rd,
	input  logic                  ex_mem_read,
	input  logic                  mem_reg_write,
	input  logic                  wb_reg_write,
	input  logic                  redirect,
	output pipe_pkg::fwd_sel_e    fwd_a,
	output pipe_pkg::fwd_sel_e    fwd_b,
	output logic                  stall,
	output logic                  flush
);
	import rv_isa_pkg::*;
	import pipe_pkg::*;

	logic load_use;

	// youngest producer wins, x0 never forwarded
	function automatic fwd_sel_e pick_source(reg_addr_t rs, reg_addr_t m_rd, logic m_we,
			reg_addr_t w_rd, logic w_we);
		if (m_we && m_rd != '0 && m_rd == rs) begin
			return FWD_MEM;
		end else if (w_we && w_rd != '0 && w_rd == rs) begin
			return FWD_WB;
		end
		return FWD_NONE;
	endfunction

	assign fwd_a = pick_source(ex_rs1, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
	assign fwd_b = pick_source(ex_rs2, mem_rd, mem_reg_write, wb_rd, wb_reg_write);

	// load in execute feeding the instruction in decode
	assign load_use = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

	// decode is squashed on redirect, so no point holding it
	assign stall = load_use && !redirect;
	assign flush = redirect;

endmodule

// File: logic/pipe_pkg.sv
package pipe_pkg;

	// operations the execute stage can ask of the ALU
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5
	} alu_op_e;

	// operand source in execute
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_MEM  = 2'd1,
		FWD_WB   = 2'd2
	} fwd_sel_e;

endpackage

// File: logic/register_file.sv
module register_file (
	input  logic                  clock,
	input  logic                  reset,
	input  rv_isa_pkg::reg_addr_t read_a,
	input  rv_isa_pkg::reg_addr_t read_b,
	output rv_isa_pkg::word_t     data_a,
	output rv_isa_pkg::word_t     data_b,
	input  rv_isa_pkg::reg_addr_t write_addr,
	input  logic                  write_enable,
	input  rv_isa_pkg::word_t     write_data
);
	import rv_isa_pkg::*;

	// x0 has no storage
	word_t regs [1:NUM_REGS-1];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable && write_addr != '0) begin
			regs[write_addr] <= write_data;
		end
	end

	// writeback in the same cycle is visible to decode
	function automatic word_t read_port(reg_addr_t addr);
		if (addr == '0) begin
			return '0;
		end else if (write_enable && write_addr == addr) begin
			return write_data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		data_a = read_port(read_a);
		data_b = read_port(read_b);
	end

endmodule

// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

	// base word and register index sizes
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	// instruction field widths
	localparam int OPCODE_W = 7;
	localparam int FUNCT3_W = 3;
	localparam int FUNCT7_W = 7;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	////////////////////////////////////////////////////////////////////////////
	// major opcodes of the kept subset
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [OPCODE_W-1:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111
	} opcode_e;

	// funct3 codes for OP and OP_IMM
	localparam logic [FUNCT3_W-1:0] FUNCT3_ADD_SUB = 3'b000;
	localparam logic [FUNCT3_W-1:0] FUNCT3_SLT     = 3'b010;
	localparam logic [FUNCT3_W-1:0] FUNCT3_XOR     = 3'b100;
	localparam logic [FUNCT3_W-1:0] FUNCT3_OR      = 3'b110;
	localparam logic [FUNCT3_W-1:0] FUNCT3_AND     = 3'b111;

	// funct7 separating sub from add
	localparam logic [FUNCT7_W-1:0] FUNCT7_SUB = 7'b0100000;

endpackage

// File: verification/cpu_tb.sv
module cpu_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import rv_isa_pkg::*;

	localparam word_t       RESET_PC    = 32'h0000_0400;
	localparam int          PROG_LEN    = 400;
	localparam int          HALT_IDX    = PROG_LEN - 1;
	localparam word_t       HALT_PC     = RESET_PC + 4 * HALT_IDX;
	localparam int          HALT_HITS   = 8;
	// three cycles per instruction plus reset tail and drain
	localparam int          CYCLE_LIMIT = 1250;
	localparam logic [31:0] SEED        = 32'h0c22bf70;
	localparam logic [2:0]  WORD_FUNCT3 = 3'b010;
	localparam logic [2:0]  BEQ_FUNCT3  = 3'b000;

	typedef enum {KIND_ADD, KIND_SUB, KIND_AND, KIND_OR, KIND_XOR, KIND_SLT,
		KIND_ADDI, KIND_LW, KIND_SW, KIND_BEQ, KIND_JAL} kind_e;

	logic  clock, reset, mem_read, mem_write;
	word_t fetch_pc, instruction, data_addr, write_data, read_data, rom_index;

	kind_e     prog_kind [PROG_LEN];
	reg_addr_t prog_rd [PROG_LEN];
	reg_addr_t prog_rs1 [PROG_LEN];
	reg_addr_t prog_rs2 [PROG_LEN];
	word_t     prog_imm [PROG_LEN];
	word_t     rom [PROG_LEN];
	word_t     ram [64];
	word_t     model_mem [64];

	// expected stores in program order
	word_t exp_addr [$];
	word_t exp_data [$];
	logic  exp_from_load [$];

	int   errors, store_count, load_use_count, halt_hits, cycles;
	logic reset_seen_high = 1'b0;

	tb_clock_gen #(.HALF_PERIOD(20), .RESET_CYCLES(16)) clock_gen_i (
		.clock(clock), .reset(reset)
	);

	cpu_pipeline #(.RESET_PC(RESET_PC)) dut_i (
		.clock(clock), .reset(reset), .fetch_pc(fetch_pc), .instruction(instruction),
		.data_addr(data_addr), .write_data(write_data), .mem_read(mem_read),
		.mem_write(mem_write), .read_data(read_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// memories, both answering in the same cycle
	////////////////////////////////////////////////////////////////////////////
	assign rom_index   = (fetch_pc - RESET_PC) >> 2;
	assign instruction = (rom_index < PROG_LEN) ? rom[rom_index] : '0;
	// data only while the read strobe is up
	assign read_data   = mem_read ? ram[data_addr[7:2]] : '0;

	always @(posedge clock) begin
		if (mem_write) begin
			ram[data_addr[7:2]] <= write_data;
		end
	end

	function automatic word_t encode(kind_e k, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2,
			word_t imm);
		case (k)
			KIND_ADD:  return {7'b0, rs2, rs1, FUNCT3_ADD_SUB, rd, OP};
			KIND_SUB:  return {FUNCT7_SUB, rs2, rs1, FUNCT3_ADD_SUB, rd, OP};
			KIND_AND:  return {7'b0, rs2, rs1, FUNCT3_AND, rd, OP};
			KIND_OR:   return {7'b0, rs2, rs1, FUNCT3_OR, rd, OP};
			KIND_XOR:  return {7'b0, rs2, rs1, FUNCT3_XOR, rd, OP};
			KIND_SLT:  return {7'b0, rs2, rs1, FUNCT3_SLT, rd, OP};
			KIND_ADDI: return {imm[11:0], rs1, FUNCT3_ADD_SUB, rd, OP_IMM};
			KIND_LW:   return {imm[11:0], rs1, WORD_FUNCT3, rd, LOAD};
			KIND_SW:   return {imm[11:5], rs2, rs1, WORD_FUNCT3, imm[4:0], STORE};
			KIND_BEQ:  return {imm[12], imm[10:5], rs2, rs1, BEQ_FUNCT3, imm[4:1], imm[11],
				BRANCH};
			default:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
		endcase
	endfunction

	// random program with registers x0..x7 and forward-only control flow
	task automatic build_program();
		int          pick;
		int          span;
		logic [31:0] bits;
		for (int i = 0; i < PROG_LEN; i++) begin
			pick        = $urandom_range(99);
			bits        = $urandom();
			span        = $urandom_range(1, 8);
			prog_rd[i]  = reg_addr_t'($urandom_range(7));
			prog_rs1[i] = reg_addr_t'($urandom_range(7));
			prog_rs2[i] = reg_addr_t'($urandom_range(7));
			prog_imm[i] = '0;
			if (i + span > HALT_IDX) begin
				span = HALT_IDX - i;
			end
			if (i == HALT_IDX) begin
				// jump to itself
				prog_kind[i] = KIND_JAL;
				prog_rd[i]   = '0;
			end else if (pick < 30) begin
				prog_kind[i] = kind_e'(int'(KIND_ADD) + $urandom_range(5));
			end else if (pick < 45) begin
				prog_kind[i] = KIND_ADDI;
				prog_imm[i]  = {{20{bits[11]}}, bits[11:0]};
			end else if (pick < 60) begin
				prog_kind[i] = KIND_LW;
				prog_rs1[i]  = '0;
				prog_rd[i]   = reg_addr_t'($urandom_range(1, 7));
				prog_imm[i]  = word_t'($urandom_range(63) * 4);
			end else if (pick < 80) begin
				prog_kind[i] = KIND_SW;
				prog_rs1[i]  = '0;
				prog_imm[i]  = word_t'($urandom_range(63) * 4);
				// store data from a recent load, to hit the load-use paths often
				if (i >= 1 && prog_kind[i-1] == KIND_LW && $urandom_range(3) != 0) begin
					prog_rs2[i] = prog_rd[i-1];
				end else if (i >= 2 && prog_kind[i-2] == KIND_LW && $urandom_range(1) == 0) begin
					prog_rs2[i] = prog_rd[i-2];
				end
			end else if (pick < 92) begin
				prog_kind[i] = KIND_BEQ;
				if ($urandom_range(2) == 0) begin
					prog_rs2[i] = prog_rs1[i];
				end
				prog_imm[i] = word_t'(span * 4);
			end else begin
				prog_kind[i] = KIND_JAL;
				prog_imm[i]  = word_t'(span * 4);
			end
			rom[i] = encode(prog_kind[i], prog_rd[i], prog_rs1[i], prog_rs2[i], prog_imm[i]);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// instruction-set model
	////////////////////////////////////////////////////////////////////////////
	task automatic run_model();
		word_t     regs [32];
		word_t     a, b, res, addr;
		reg_addr_t ld1, ld2, wr1, wr_now, ld_now;
		int        idx, next;
		foreach (regs[r]) begin
			regs[r] = '0;
		end
		ld1 = '0;
		ld2 = '0;
		wr1 = '0;
		idx = 0;
		while (idx != HALT_IDX) begin
			a      = regs[prog_rs1[idx]];
			b      = regs[prog_rs2[idx]];
			res    = '0;
			wr_now = prog_rd[idx];
			ld_now = '0;
			next   = idx + 1;
			case (prog_kind[idx])
				KIND_ADD:  res = a + b;
				KIND_SUB:  res = a - b;
				KIND_AND:  res = a & b;
				KIND_OR:   res = a | b;
				KIND_XOR:  res = a ^ b;
				KIND_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				KIND_ADDI: res = a + prog_imm[idx];
				KIND_LW: begin
					addr   = a + prog_imm[idx];
					res    = model_mem[addr[7:2]];
					ld_now = prog_rd[idx];
				end
				KIND_SW: begin
					addr   = a + prog_imm[idx];
					wr_now = '0;
					model_mem[addr[7:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
					exp_from_load.push_back(prog_rs2[idx] != '0 && (ld1 == prog_rs2[idx]
						|| (ld2 == prog_rs2[idx] && wr1 != prog_rs2[idx])));
				end
				KIND_BEQ: begin
					wr_now = '0;
					if (a == b) begin
						next = idx + int'(prog_imm[idx] >> 2);
					end
				end
				default: begin
					res  = RESET_PC + word_t'(idx * 4 + 4);
					next = idx + int'(prog_imm[idx] >> 2);
				end
			endcase
			if (wr_now != '0) begin
				regs[wr_now] = res;
			end
			ld2 = ld1;
			ld1 = ld_now;
			wr1 = wr_now;
			idx = next;
		end
	endtask

	task automatic check_store();
		string name;
		word_t ea, ed;
		assert (exp_addr.size() != 0) else begin
			$display("a store to %h appeared after the model's last store", data_addr);
			errors++;
		end
		if (exp_addr.size() != 0) begin
			ea   = exp_addr.pop_front();
			ed   = exp_data.pop_front();
			name = exp_from_load.pop_front() ? "load_use" : "store_order";
			if (name == "load_use") begin
				load_use_count++;
			end
			assert (data_addr == ea) else begin
				$display("ERROR %s: address expected %h, actual %h", name, ea, data_addr);
				errors++;
			end
			assert (write_data == ed) else begin
				$display("ERROR %s: data expected %h, actual %h", name, ed, write_data);
				errors++;
			end
		end
		store_count++;
	endtask

	// outputs sampled mid-cycle, away from the rising edge
	always @(negedge clock) begin
		if (!reset || !reset_seen_high) begin
			assert (mem_read == 1'b0 && mem_write == 1'b0) else begin
				$display("ERROR reset_state: strobes expected 00, actual %b%b", mem_read,
					mem_write);
				errors++;
			end
			assert (fetch_pc == RESET_PC) else begin
				$display("ERROR reset_state: fetch_pc expected %h, actual %h", RESET_PC,
					fetch_pc);
				errors++;
			end
			reset_seen_high = reset;
		end else begin
			if (mem_write) begin
				check_store();
			end
			if (fetch_pc == HALT_PC) begin
				halt_hits++;
			end
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			cycles++;
		end
	end

	initial begin
		int model_stores;
		void'($urandom(SEED));
		build_program();
		for (int i = 0; i < 64; i++) begin
			ram[i]       = $urandom();
			model_mem[i] = ram[i];
		end
		run_model();
		model_stores = exp_addr.size();
		@(posedge reset);
		while (halt_hits < HALT_HITS && cycles < CYCLE_LIMIT) begin
			@(posedge clock);
		end
		if (halt_hits < HALT_HITS) begin
			$display("timeout: the program did not reach its halt loop within %0d cycles",
				CYCLE_LIMIT);
			errors++;
		end else begin
			assert (store_count == model_stores) else begin
				$display("ERROR control_flow: expected %0d stores, actual %0d", model_stores,
					store_count);
				errors++;
			end
			for (int i = 0; i < 64; i++) begin
				assert (ram[i] == model_mem[i]) else begin
					$display("ERROR memory_image: word %0d expected %h, actual %h", i,
						model_mem[i], ram[i]);
					errors++;
				end
			end
		end
		$display("%0d stores checked, %0d fed by a load, %0d errors", store_count,
			load_use_count, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int HALF_PERIOD  = 20,
	parameter int RESET_CYCLES = 16
) (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	// reset held low, then released on a rising edge
	initial begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b1;
	end

endmodule
